// File: verilog/gpu_unit_settings.svh
`ifndef GPU_UNIT_SETTINGS_SVH
`define GPU_UNIT_SETTINGS_SVH

// lanes per warp
`define NUM_THREADS 4

// warps per core
`define NUM_WARPS 4

// warp id width
`define NW_BITS 2

// barrier id width
`define NB_BITS 2

// register index width
`define NR_BITS 5

`endif

// File: verilog/gpu_unit_pkg.sv
`include "gpu_unit_settings.svh"

package gpu_unit_pkg;

    typedef logic [31:0] word_t;
    typedef word_t [`NUM_THREADS-1:0] lanes_t;
    typedef logic [`NUM_THREADS-1:0] tmask_t;
    typedef logic [`NUM_WARPS-1:0] wmask_t;
    typedef logic [`NW_BITS-1:0] wid_t;
    typedef logic [`NB_BITS-1:0] bid_t;
    typedef logic [`NR_BITS-1:0] reg_t;
    typedef logic [1:0] tid_t;
    typedef logic [2:0] op_t;

    localparam op_t OP_TMC    = 3'd0;
    localparam op_t OP_WSPAWN = 3'd1;
    localparam op_t OP_SPLIT  = 3'd2;
    localparam op_t OP_JOIN   = 3'd3;
    localparam op_t OP_BAR    = 3'd4;
    localparam op_t OP_PRED   = 3'd5;
    localparam op_t OP_IMADD  = 3'd6;

    // {wid, tmask, pc, rd}
    localparam int TAG_W = `NW_BITS + `NUM_THREADS + 32 + `NR_BITS;
    typedef logic [TAG_W-1:0] tag_t;

    // tmc, wspawn, split and barrier fields back to back
    localparam int WCTL_W = (1 + `NUM_THREADS) + (1 + `NUM_WARPS + 32)
                          + (2 + 2 * `NUM_THREADS + 32) + (1 + `NB_BITS + `NW_BITS);
    typedef logic [WCTL_W-1:0] wctl_t;

    localparam int LANES_W = `NUM_THREADS * 32;
    localparam int RSP_W   = (LANES_W > WCTL_W) ? LANES_W : WCTL_W;
    typedef logic [RSP_W-1:0] rsp_t;

    // commit entry is {tag, wb, data, eop, is_wctl}
    localparam int ENTRY_W = TAG_W + 1 + RSP_W + 1 + 1;
    typedef logic [ENTRY_W-1:0] entry_t;

    typedef enum logic {
        PRI_WCTL,
        PRI_IMADD
    } arb_sel_t;

endpackage

// File: verilog/warp_ctl_decode.sv
`include "gpu_unit_settings.svh"

module warp_ctl_decode (
    input  gpu_unit_pkg::op_t    op,
    input  gpu_unit_pkg::tmask_t tmask,
    input  gpu_unit_pkg::tid_t   tid,
    input  gpu_unit_pkg::word_t  next_pc,
    input  gpu_unit_pkg::lanes_t rs1_data,
    input  gpu_unit_pkg::lanes_t rs2_data,
    output gpu_unit_pkg::wctl_t  wctl
);

    gpu_unit_pkg::word_t  rs1_lane;
    gpu_unit_pkg::word_t  rs2_lane;
    gpu_unit_pkg::tmask_t taken_tmask;
    gpu_unit_pkg::tmask_t not_taken_tmask;
    gpu_unit_pkg::tmask_t tmc_tmask;
    gpu_unit_pkg::wmask_t wspawn_wmask;
    gpu_unit_pkg::wid_t   bar_size_m1;
    logic                 is_tmc;
    logic                 is_pred;
    logic                 is_wspawn;
    logic                 is_split;
    logic                 is_bar;
    logic                 split_diverged;

    assign is_tmc    = (op == gpu_unit_pkg::OP_TMC);
    assign is_pred   = (op == gpu_unit_pkg::OP_PRED);
    assign is_wspawn = (op == gpu_unit_pkg::OP_WSPAWN);
    assign is_split  = (op == gpu_unit_pkg::OP_SPLIT);
    assign is_bar    = (op == gpu_unit_pkg::OP_BAR);

    // scalar operands come from the lane named by tid
    assign rs1_lane = rs1_data[tid];
    assign rs2_lane = rs2_data[tid];

    always_comb begin
        for (int i = 0; i < `NUM_THREADS; i++) begin
            taken_tmask[i]     = tmask[i] && (rs1_data[i] != '0);
            not_taken_tmask[i] = tmask[i] && (rs1_data[i] == '0);
        end
    end

    always_comb begin
        for (int i = 0; i < `NUM_WARPS; i++) begin
            wspawn_wmask[i] = (gpu_unit_pkg::word_t'(i) < rs1_lane);
        end
    end

    // pred falls back to the active mask when nothing is taken
    always_comb begin
        if (is_pred) begin
            tmc_tmask = (taken_tmask != '0) ? taken_tmask : tmask;
        end else begin
            tmc_tmask = rs1_lane[`NUM_THREADS-1:0];
        end
    end

    assign split_diverged = (|taken_tmask) && (|not_taken_tmask);
    assign bar_size_m1    = gpu_unit_pkg::wid_t'(rs2_lane - 32'd1);

    assign wctl = {is_tmc | is_pred, tmc_tmask,
                   is_wspawn, wspawn_wmask, rs2_lane,
                   is_split, split_diverged, taken_tmask, not_taken_tmask, next_pc,
                   is_bar, rs1_lane[`NB_BITS-1:0], bar_size_m1};

endmodule

// File: verilog/imadd_pipe.sv
`include "gpu_unit_settings.svh"

module imadd_pipe (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic [4:0]           shift,
    input  gpu_unit_pkg::lanes_t a,
    input  gpu_unit_pkg::lanes_t b,
    input  gpu_unit_pkg::lanes_t c,
    input  gpu_unit_pkg::tag_t   in_tag,
    output logic                 out_valid,
    input  logic                 out_ready,
    output gpu_unit_pkg::tag_t   out_tag,
    output gpu_unit_pkg::lanes_t out_data
);

    logic                 s1_valid;
    logic                 s1_ready;
    logic                 s2_ready;
    logic [4:0]           s1_shift;
    logic signed [63:0]   prod [`NUM_THREADS];
    logic signed [63:0]   s1_prod [`NUM_THREADS];
    logic signed [63:0]   shifted [`NUM_THREADS];
    gpu_unit_pkg::lanes_t s1_c;
    gpu_unit_pkg::tag_t   s1_tag;
    gpu_unit_pkg::lanes_t sum;

    // each stage moves when empty or when the next one moves
    assign s2_ready = ~out_valid | out_ready;
    assign s1_ready = ~s1_valid | s2_ready;
    assign in_ready = s1_ready;

    always_comb begin
        for (int i = 0; i < `NUM_THREADS; i++) begin
            prod[i] = $signed(a[i]) * $signed(b[i]);
        end
    end

    // only the low word of the sum is kept
    always_comb begin
        for (int i = 0; i < `NUM_THREADS; i++) begin
            shifted[i] = s1_prod[i] >>> s1_shift;
            sum[i]     = shifted[i][31:0] + s1_c[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (s1_ready) begin
                s1_valid <= in_valid;
            end
            if (s2_ready) begin
                out_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_ready && in_valid) begin
            s1_prod  <= prod;
            s1_shift <= shift;
            s1_c     <= c;
            s1_tag   <= in_tag;
        end
        if (s2_ready && s1_valid) begin
            out_data <= sum;
            out_tag  <= s1_tag;
        end
    end

endmodule

// File: verilog/commit_arb.sv
module commit_arb (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wctl_valid,
    output logic                 wctl_ready,
    input  gpu_unit_pkg::entry_t wctl_entry,
    input  logic                 imadd_valid,
    output logic                 imadd_ready,
    input  gpu_unit_pkg::entry_t imadd_entry,
    output logic                 out_valid,
    input  logic                 out_ready,
    output gpu_unit_pkg::entry_t out_entry
);

    gpu_unit_pkg::arb_sel_t pri;
    logic                   buf_ready;
    logic                   wctl_fire;
    logic                   imadd_fire;

    // buffer takes a new entry when empty or draining
    assign buf_ready = ~out_valid | out_ready;

    // a side is refused only while the other side holds priority and asks
    assign wctl_ready  = buf_ready
                       & ~(imadd_valid & (pri == gpu_unit_pkg::PRI_IMADD));
    assign imadd_ready = buf_ready
                       & ~(wctl_valid & (pri == gpu_unit_pkg::PRI_WCTL));

    assign wctl_fire  = wctl_valid & wctl_ready;
    assign imadd_fire = imadd_valid & imadd_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            pri       <= gpu_unit_pkg::PRI_WCTL;
        end else begin
            if (buf_ready) begin
                out_valid <= wctl_fire | imadd_fire;
            end
            // hand priority to the side that did not win
            if (wctl_fire) begin
                pri <= gpu_unit_pkg::PRI_IMADD;
            end else if (imadd_fire) begin
                pri <= gpu_unit_pkg::PRI_WCTL;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wctl_fire) begin
            out_entry <= wctl_entry;
        end else if (imadd_fire) begin
            out_entry <= imadd_entry;
        end
    end

endmodule

// File: verilog/gpu_unit.sv
module gpu_unit (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 req_valid,
    output logic                 req_ready,
    input  gpu_unit_pkg::op_t    req_op,
    input  logic [1:0]           req_op_mod,
    input  gpu_unit_pkg::wid_t   req_wid,
    input  gpu_unit_pkg::tmask_t req_tmask,
    input  gpu_unit_pkg::tid_t   req_tid,
    input  gpu_unit_pkg::word_t  req_pc,
    input  gpu_unit_pkg::word_t  req_next_pc,
    input  gpu_unit_pkg::reg_t   req_rd,
    input  gpu_unit_pkg::lanes_t req_rs1_data,
    input  gpu_unit_pkg::lanes_t req_rs2_data,
    input  gpu_unit_pkg::lanes_t req_rs3_data,

    output logic                 commit_valid,
    input  logic                 commit_ready,
    output gpu_unit_pkg::wid_t   commit_wid,
    output gpu_unit_pkg::tmask_t commit_tmask,
    output gpu_unit_pkg::word_t  commit_pc,
    output gpu_unit_pkg::reg_t   commit_rd,
    output logic                 commit_wb,
    output gpu_unit_pkg::lanes_t commit_data,
    output logic                 commit_eop,

    output logic                 wctl_valid,
    output gpu_unit_pkg::wid_t   wctl_wid,
    output logic                 wctl_tmc_valid,
    output gpu_unit_pkg::tmask_t wctl_tmc_tmask,
    output logic                 wctl_wspawn_valid,
    output gpu_unit_pkg::wmask_t wctl_wspawn_wmask,
    output gpu_unit_pkg::word_t  wctl_wspawn_pc,
    output logic                 wctl_split_valid,
    output logic                 wctl_split_diverged,
    output gpu_unit_pkg::tmask_t wctl_split_then_tmask,
    output gpu_unit_pkg::tmask_t wctl_split_else_tmask,
    output gpu_unit_pkg::word_t  wctl_split_pc,
    output logic                 wctl_bar_valid,
    output gpu_unit_pkg::bid_t   wctl_bar_id,
    output gpu_unit_pkg::wid_t   wctl_bar_size_m1,

    input  logic                 csr_pending,
    output logic                 req_pending
);

    logic                 req_valid_int;
    logic                 is_imadd;
    logic                 wctl_req_valid;
    logic                 wctl_req_ready;
    logic                 imadd_in_valid;
    logic                 imadd_in_ready;
    logic                 imadd_out_valid;
    logic                 imadd_out_ready;
    gpu_unit_pkg::tag_t   imadd_out_tag;
    gpu_unit_pkg::lanes_t imadd_out_data;
    gpu_unit_pkg::wctl_t  wctl_fields;
    gpu_unit_pkg::entry_t wctl_entry;
    gpu_unit_pkg::entry_t imadd_entry;
    gpu_unit_pkg::entry_t out_entry;
    gpu_unit_pkg::rsp_t   rsp_data;
    logic                 rsp_is_wctl;

    // no new work while a csr access is in flight
    assign req_valid_int  = req_valid & ~csr_pending;
    assign is_imadd       = (req_op == gpu_unit_pkg::OP_IMADD);
    assign wctl_req_valid = req_valid_int & ~is_imadd;
    assign imadd_in_valid = req_valid_int & is_imadd;
    assign req_ready      = ~csr_pending & (is_imadd ? imadd_in_ready : wctl_req_ready);

    warp_ctl_decode u_decode (
        .op       (req_op),
        .tmask    (req_tmask),
        .tid      (req_tid),
        .next_pc  (req_next_pc),
        .rs1_data (req_rs1_data),
        .rs2_data (req_rs2_data),
        .wctl     (wctl_fields)
    );

    // join retires through commit but drives no warp-control update
    assign wctl_entry = {req_wid, req_tmask, req_pc, gpu_unit_pkg::reg_t'(0), 1'b0,
                         gpu_unit_pkg::rsp_t'(wctl_fields), 1'b1,
                         req_op != gpu_unit_pkg::OP_JOIN};

    imadd_pipe u_imadd (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (imadd_in_valid),
        .in_ready  (imadd_in_ready),
        .shift     ({req_op_mod, 3'b000}),
        .a         (req_rs1_data),
        .b         (req_rs2_data),
        .c         (req_rs3_data),
        .in_tag    ({req_wid, req_tmask, req_pc, req_rd}),
        .out_valid (imadd_out_valid),
        .out_ready (imadd_out_ready),
        .out_tag   (imadd_out_tag),
        .out_data  (imadd_out_data)
    );

    assign imadd_entry = {imadd_out_tag, 1'b1, gpu_unit_pkg::rsp_t'(imadd_out_data), 1'b1, 1'b0};

    commit_arb u_arb (
        .clk         (clk),
        .reset       (reset),
        .wctl_valid  (wctl_req_valid),
        .wctl_ready  (wctl_req_ready),
        .wctl_entry  (wctl_entry),
        .imadd_valid (imadd_out_valid),
        .imadd_ready (imadd_out_ready),
        .imadd_entry (imadd_entry),
        .out_valid   (commit_valid),
        .out_ready   (commit_ready),
        .out_entry   (out_entry)
    );

    assign {commit_wid, commit_tmask, commit_pc, commit_rd, commit_wb,
            rsp_data, commit_eop, rsp_is_wctl} = out_entry;
    assign commit_data = rsp_data[gpu_unit_pkg::LANES_W-1:0];

    // warp-control update fires with the commit handshake
    assign wctl_valid = commit_valid & commit_ready & rsp_is_wctl;
    assign wctl_wid   = commit_wid;
    assign {wctl_tmc_valid, wctl_tmc_tmask,
            wctl_wspawn_valid, wctl_wspawn_wmask, wctl_wspawn_pc,
            wctl_split_valid, wctl_split_diverged, wctl_split_then_tmask,
            wctl_split_else_tmask, wctl_split_pc,
            wctl_bar_valid, wctl_bar_id, wctl_bar_size_m1} = rsp_data[gpu_unit_pkg::WCTL_W-1:0];

    // a commit in the same cycle as a new accept clears the flag
    always_ff @(posedge clk) begin
        if (reset) begin
            req_pending <= 1'b0;
        end else if (commit_valid && commit_ready) begin
            req_pending <= 1'b0;
        end else if (req_valid && req_ready) begin
            req_pending <= 1'b1;
        end
    end

endmodule

// File: bench/gpu_unit_asserts.sv
module gpu_unit_asserts (
    input logic                 clk,
    input logic                 reset,
    input logic                 req_valid,
    input logic                 req_ready,
    input gpu_unit_pkg::op_t    req_op,
    input gpu_unit_pkg::wid_t   req_wid,
    input gpu_unit_pkg::tmask_t req_tmask,
    input gpu_unit_pkg::word_t  req_pc,
    input gpu_unit_pkg::lanes_t req_rs1_data,
    input gpu_unit_pkg::lanes_t req_rs2_data,
    input gpu_unit_pkg::lanes_t req_rs3_data,
    input logic                 commit_valid,
    input logic                 commit_ready,
    input gpu_unit_pkg::wid_t   commit_wid,
    input gpu_unit_pkg::tmask_t commit_tmask,
    input gpu_unit_pkg::word_t  commit_pc,
    input gpu_unit_pkg::reg_t   commit_rd,
    input logic                 commit_wb,
    input gpu_unit_pkg::lanes_t commit_data,
    input logic                 commit_eop,
    input logic                 wctl_valid,
    input logic                 req_pending
);
    timeunit 1ns;
    timeprecision 1ps;

    // issue side must hold a stalled request
    req_hold: assert property (@(posedge clk) disable iff (reset)
        req_valid && !req_ready |=> req_valid
            && $stable({req_op, req_wid, req_tmask, req_pc,
                        req_rs1_data, req_rs2_data, req_rs3_data}))
        else $error("request dropped or changed while stalled");

    commit_hold: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid
            && $stable({commit_wid, commit_tmask, commit_pc, commit_rd,
                        commit_wb, commit_data, commit_eop}))
        else $error("commit dropped or changed under back-pressure");

    // warp-control updates only come from non-writeback entries
    wctl_on_commit: assert property (@(posedge clk) disable iff (reset)
        wctl_valid |-> commit_valid && commit_ready && !commit_wb)
        else $error("warp-control update without a warp-control commit handshake");

    // outputs idle right after reset
    reset_idle: assert property (@(posedge clk)
        reset |=> !commit_valid && !req_pending)
        else $error("commit_valid or req_pending high after reset");

endmodule

// File: bench/gpu_unit_tb.sv
module gpu_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS   = 14;
    localparam int CSR_ROW    = 7;
    localparam int CLK_PERIOD = 8;
    localparam gpu_unit_pkg::lanes_t NO_LANES = '0;

    typedef struct packed {
        gpu_unit_pkg::op_t    op;
        logic [1:0]           mod;
        gpu_unit_pkg::wid_t   wid;
        gpu_unit_pkg::tmask_t tmask;
        gpu_unit_pkg::tid_t   tid;
        gpu_unit_pkg::lanes_t rs1;
        gpu_unit_pkg::lanes_t rs2;
        gpu_unit_pkg::lanes_t rs3;
        gpu_unit_pkg::word_t  pc;
        gpu_unit_pkg::word_t  next_pc;
        gpu_unit_pkg::reg_t   rd;
        logic [7:0]           exp_mask;
        logic                 exp_flag;
        gpu_unit_pkg::word_t  exp_pc;
        gpu_unit_pkg::lanes_t exp_data;
    } row_t;

    logic                 clk;
    logic                 reset;
    logic                 req_valid;
    logic                 req_ready;
    gpu_unit_pkg::op_t    req_op;
    logic [1:0]           req_op_mod;
    gpu_unit_pkg::wid_t   req_wid;
    gpu_unit_pkg::tmask_t req_tmask;
    gpu_unit_pkg::tid_t   req_tid;
    gpu_unit_pkg::word_t  req_pc;
    gpu_unit_pkg::word_t  req_next_pc;
    gpu_unit_pkg::reg_t   req_rd;
    gpu_unit_pkg::lanes_t req_rs1_data;
    gpu_unit_pkg::lanes_t req_rs2_data;
    gpu_unit_pkg::lanes_t req_rs3_data;
    logic                 commit_valid;
    logic                 commit_ready;
    gpu_unit_pkg::wid_t   commit_wid;
    gpu_unit_pkg::tmask_t commit_tmask;
    gpu_unit_pkg::word_t  commit_pc;
    gpu_unit_pkg::reg_t   commit_rd;
    logic                 commit_wb;
    gpu_unit_pkg::lanes_t commit_data;
    logic                 commit_eop;
    logic                 wctl_valid;
    gpu_unit_pkg::wid_t   wctl_wid;
    logic                 wctl_tmc_valid;
    gpu_unit_pkg::tmask_t wctl_tmc_tmask;
    logic                 wctl_wspawn_valid;
    gpu_unit_pkg::wmask_t wctl_wspawn_wmask;
    gpu_unit_pkg::word_t  wctl_wspawn_pc;
    logic                 wctl_split_valid;
    logic                 wctl_split_diverged;
    gpu_unit_pkg::tmask_t wctl_split_then_tmask;
    gpu_unit_pkg::tmask_t wctl_split_else_tmask;
    gpu_unit_pkg::word_t  wctl_split_pc;
    logic                 wctl_bar_valid;
    gpu_unit_pkg::bid_t   wctl_bar_id;
    gpu_unit_pkg::wid_t   wctl_bar_size_m1;
    logic                 csr_pending;
    logic                 req_pending;

    row_t   table_rows [NUM_ROWS];
    string  row_name [NUM_ROWS] = '{"tmc", "pred_taken", "pred_none", "imadd_sh0",
                                    "imadd_sh8", "imadd_sh16", "imadd_sh24", "wspawn",
                                    "split_div", "split_uni", "join", "bar",
                                    "imadd_tail", "tmc_all"};
    int     wctl_q [$];
    int     imadd_q [$];
    int     commits = 0;
    integer seed = 43485;

    gpu_unit u_dut (.*);

    bind gpu_unit gpu_unit_asserts u_asserts (
        .clk(clk), .reset(reset), .req_valid(req_valid), .req_ready(req_ready),
        .req_op(req_op), .req_wid(req_wid), .req_tmask(req_tmask), .req_pc(req_pc),
        .req_rs1_data(req_rs1_data), .req_rs2_data(req_rs2_data),
        .req_rs3_data(req_rs3_data), .commit_valid(commit_valid),
        .commit_ready(commit_ready), .commit_wid(commit_wid), .commit_tmask(commit_tmask),
        .commit_pc(commit_pc), .commit_rd(commit_rd), .commit_wb(commit_wb),
        .commit_data(commit_data), .commit_eop(commit_eop), .wctl_valid(wctl_valid),
        .req_pending(req_pending)
    );

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [127:0] expected, input logic [127:0] actual);
        assert (actual === expected) else
            report_error($sformatf("mismatch %s %s: expected %0h, actual %0h",
                                   name, field, expected, actual));
    endtask

    // lanes are written lane 3 first; expected values worked out by hand
    task automatic load_table();
        table_rows[0] = '{gpu_unit_pkg::OP_TMC, 2'd0, 2'd1, 4'hf, 2'd2,
            {32'h0, 32'h6, 32'h0, 32'h0}, NO_LANES, NO_LANES,
            32'h100, 32'h104, 5'd0, 8'h06, 1'b0, 32'h0, NO_LANES};
        table_rows[1] = '{gpu_unit_pkg::OP_PRED, 2'd0, 2'd0, 4'hb, 2'd0,
            {32'h1, 32'h0, 32'h0, 32'h7}, NO_LANES, NO_LANES,
            32'h108, 32'h10c, 5'd0, 8'h09, 1'b0, 32'h0, NO_LANES};
        table_rows[2] = '{gpu_unit_pkg::OP_PRED, 2'd0, 2'd3, 4'h6, 2'd1,
            {32'h5, 32'h0, 32'h0, 32'h9}, NO_LANES, NO_LANES,
            32'h110, 32'h114, 5'd0, 8'h06, 1'b0, 32'h0, NO_LANES};
        table_rows[3] = '{gpu_unit_pkg::OP_IMADD, 2'd0, 2'd2, 4'hf, 2'd0,
            {32'h3, 32'hfffffffe, 32'd100000, 32'h7},
            {32'h4, 32'h5, 32'd100000, 32'hfffffffd},
            {32'h1, 32'ha, 32'h0, 32'h64}, 32'h200, 32'h204, 5'd7, 8'h00, 1'b0, 32'h0,
            {32'hd, 32'h0, 32'h540be400, 32'h4f}};
        table_rows[4] = '{gpu_unit_pkg::OP_IMADD, 2'd1, 2'd1, 4'h7, 2'd0,
            {32'h100, 32'hffffff00, 32'h12345, 32'h2},
            {32'h100, 32'h1, 32'h100, 32'h3},
            {32'h0, 32'h0, 32'h0, 32'h5}, 32'h208, 32'h20c, 5'd8, 8'h00, 1'b0, 32'h0,
            {32'h100, 32'hffffffff, 32'h12345, 32'h5}};
        table_rows[5] = '{gpu_unit_pkg::OP_IMADD, 2'd2, 2'd0, 4'hf, 2'd0,
            {32'h10000, 32'h7fffffff, 32'hffff0000, 32'h30000},
            {32'h10000, 32'h7fffffff, 32'h3, 32'h2},
            {32'h1, 32'h0, 32'h7, 32'h0}, 32'h20c, 32'h210, 5'd9, 8'h00, 1'b0, 32'h0,
            {32'h10001, 32'hffff0000, 32'h4, 32'h6}};
        table_rows[6] = '{gpu_unit_pkg::OP_IMADD, 2'd3, 2'd3, 4'hf, 2'd0,
            {32'hffffffff, 32'h01000000, 32'h40000000, 32'h5},
            {32'hffffffff, 32'h01000000, 32'hfffffffc, 32'h0},
            {32'h0, 32'h10, 32'h20, 32'hdeadbeef}, 32'h210, 32'h214, 5'd31, 8'h00, 1'b0,
            32'h0, {32'h0, 32'h01000010, 32'hffffff20, 32'hdeadbeef}};
        table_rows[7] = '{gpu_unit_pkg::OP_WSPAWN, 2'd0, 2'd0, 4'h1, 2'd1,
            {32'h0, 32'h0, 32'h3, 32'h0}, {32'h0, 32'h0, 32'h80001000, 32'h0}, NO_LANES,
            32'h300, 32'h304, 5'd0, 8'h07, 1'b0, 32'h80001000, NO_LANES};
        table_rows[8] = '{gpu_unit_pkg::OP_SPLIT, 2'd0, 2'd2, 4'he, 2'd0,
            {32'h0, 32'h1, 32'h0, 32'h5}, NO_LANES, NO_LANES,
            32'h310, 32'h314, 5'd0, 8'h4a, 1'b1, 32'h314, NO_LANES};
        table_rows[9] = '{gpu_unit_pkg::OP_SPLIT, 2'd0, 2'd1, 4'h3, 2'd0,
            {32'h0, 32'h0, 32'h2, 32'h1}, NO_LANES, NO_LANES,
            32'h318, 32'h31c, 5'd0, 8'h30, 1'b0, 32'h31c, NO_LANES};
        table_rows[10] = '{gpu_unit_pkg::OP_JOIN, 2'd0, 2'd3, 4'h5, 2'd0,
            NO_LANES, NO_LANES, NO_LANES,
            32'h320, 32'h324, 5'd0, 8'h00, 1'b0, 32'h0, NO_LANES};
        table_rows[11] = '{gpu_unit_pkg::OP_BAR, 2'd0, 2'd2, 4'hf, 2'd3,
            {32'h6, 32'h0, 32'h0, 32'h0}, {32'h4, 32'h0, 32'h0, 32'h0}, NO_LANES,
            32'h324, 32'h328, 5'd0, 8'h0b, 1'b0, 32'h0, NO_LANES};
        table_rows[12] = '{gpu_unit_pkg::OP_IMADD, 2'd0, 2'd1, 4'hf, 2'd0,
            {32'h2, 32'h2, 32'h2, 32'h2}, {32'h3, 32'h3, 32'h3, 32'h3},
            {32'h1, 32'h2, 32'h3, 32'h4}, 32'h328, 32'h32c, 5'd3, 8'h00, 1'b0, 32'h0,
            {32'h7, 32'h8, 32'h9, 32'ha}};
        table_rows[13] = '{gpu_unit_pkg::OP_TMC, 2'd0, 2'd0, 4'h1, 2'd0,
            {32'h0, 32'h0, 32'h0, 32'h1f}, NO_LANES, NO_LANES,
            32'h32c, 32'h330, 5'd0, 8'h0f, 1'b0, 32'h0, NO_LANES};
    endtask

    task automatic drive_row(input int i);
        req_valid    <= 1'b1;
        req_op       <= table_rows[i].op;
        req_op_mod   <= table_rows[i].mod;
        req_wid      <= table_rows[i].wid;
        req_tmask    <= table_rows[i].tmask;
        req_tid      <= table_rows[i].tid;
        req_pc       <= table_rows[i].pc;
        req_next_pc  <= table_rows[i].next_pc;
        req_rd       <= table_rows[i].rd;
        req_rs1_data <= table_rows[i].rs1;
        req_rs2_data <= table_rows[i].rs2;
        req_rs3_data <= table_rows[i].rs3;
    endtask

    // each path commits in its own issue order
    task automatic check_commit();
        int    idx;
        row_t  r;
        string nm;
        if (commit_wb) begin
            assert (imadd_q.size() > 0) else
                report_error("multiply-add result committed with none outstanding");
            idx = imadd_q.pop_front();
        end else begin
            assert (wctl_q.size() > 0) else
                report_error("warp-control result committed with none outstanding");
            idx = wctl_q.pop_front();
        end
        r  = table_rows[idx];
        nm = row_name[idx];
        check_value(nm, "wid", r.wid, commit_wid);
        check_value(nm, "tmask", r.tmask, commit_tmask);
        check_value(nm, "pc", r.pc, commit_pc);
        check_value(nm, "eop", 1'b1, commit_eop);
        if (r.op == gpu_unit_pkg::OP_IMADD) begin
            check_value(nm, "rd", r.rd, commit_rd);
            check_value(nm, "wctl_valid", 1'b0, wctl_valid);
            check_value(nm, "data", r.exp_data, commit_data);
        end else begin
            check_value(nm, "rd", 5'd0, commit_rd);
            check_value(nm, "wctl_valid", r.op != gpu_unit_pkg::OP_JOIN, wctl_valid);
            check_value(nm, "wctl_wid", r.wid, wctl_wid);
            check_value(nm, "valid flags",
                {r.op == gpu_unit_pkg::OP_TMC || r.op == gpu_unit_pkg::OP_PRED,
                 r.op == gpu_unit_pkg::OP_WSPAWN, r.op == gpu_unit_pkg::OP_SPLIT,
                 r.op == gpu_unit_pkg::OP_BAR},
                {wctl_tmc_valid, wctl_wspawn_valid, wctl_split_valid, wctl_bar_valid});
            case (r.op)
                gpu_unit_pkg::OP_TMC, gpu_unit_pkg::OP_PRED: begin
                    check_value(nm, "tmc_tmask", r.exp_mask[3:0], wctl_tmc_tmask);
                end
                gpu_unit_pkg::OP_WSPAWN: begin
                    check_value(nm, "wspawn_wmask", r.exp_mask[3:0], wctl_wspawn_wmask);
                    check_value(nm, "wspawn_pc", r.exp_pc, wctl_wspawn_pc);
                end
                gpu_unit_pkg::OP_SPLIT: begin
                    check_value(nm, "split masks", r.exp_mask,
                                {wctl_split_then_tmask, wctl_split_else_tmask});
                    check_value(nm, "split_diverged", r.exp_flag, wctl_split_diverged);
                    check_value(nm, "split_pc", r.exp_pc, wctl_split_pc);
                end
                gpu_unit_pkg::OP_BAR: begin
                    check_value(nm, "bar id/size_m1", r.exp_mask[3:0],
                                {wctl_bar_id, wctl_bar_size_m1});
                end
                default: begin
                end
            endcase
        end
        commits++;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // random back-pressure on the commit port
    initial begin
        forever begin
            @(posedge clk);
            commit_ready <= (($random(seed) & 3) != 0);
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (!reset && commit_valid && commit_ready) begin
                check_commit();
            end
        end
    end

    initial begin
        repeat (NUM_ROWS * 40) @(posedge clk);
        report_error("timeout: not all requests were accepted and committed");
    end

    initial begin
        reset        = 1'b1;
        req_valid    = 1'b0;
        req_op       = '0;
        req_op_mod   = '0;
        req_wid      = '0;
        req_tmask    = '0;
        req_tid      = '0;
        req_pc       = '0;
        req_next_pc  = '0;
        req_rd       = '0;
        req_rs1_data = '0;
        req_rs2_data = '0;
        req_rs3_data = '0;
        commit_ready = 1'b0;
        csr_pending  = 1'b0;
        load_table();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            drive_row(i);
            if (i == CSR_ROW) begin
                csr_pending <= 1'b1;
                repeat (4) begin
                    @(negedge clk);
                    assert (!req_ready) else
                        report_error("req_ready high while a CSR access is pending");
                end
                @(posedge clk);
                csr_pending <= 1'b0;
            end
            @(negedge clk);
            while (!req_ready) @(negedge clk);
            if (table_rows[i].op == gpu_unit_pkg::OP_IMADD) begin
                imadd_q.push_back(i);
            end else begin
                wctl_q.push_back(i);
            end
            @(posedge clk);
            // first accept cannot meet a commit in the same cycle
            if (i == 0) begin
                req_valid <= 1'b0;
                @(negedge clk);
                assert (req_pending) else
                    report_error("req_pending low after a request was accepted");
                @(posedge clk);
            end
        end
        req_valid <= 1'b0;
        wait (commits == NUM_ROWS);
        @(posedge clk);
        @(negedge clk);
        if (!req_pending && !commit_valid) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            report_error("unit not idle after all requests committed");
        end
    end

endmodule

// File: project.f
+incdir+verilog
verilog/gpu_unit_pkg.sv
verilog/warp_ctl_decode.sv
verilog/imadd_pipe.sv
verilog/commit_arb.sv
verilog/gpu_unit.sv
bench/gpu_unit_asserts.sv
bench/gpu_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f project.f --top-module gpu_unit_tb -o sim_gpu_unit \
    && ./obj_dir/sim_gpu_unit > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log 2>/dev/null && echo "run passed" \
    || { echo "run failed"; exit 1; }
